// File: tb/bus_stim.txt
# op addr data expect: W write (expect = int_req driven with it), R read and check,
# Q request pulse of data bits, F check boot_done=addr ie_flags=data if_flags=expect
F 0000 00 00
R FF0F 00 00
W C000 A5 00
R C000 00 A5
R E000 00 A5
W FDFF 3C 00
R DDFF 00 3C
R 0000 00 5A
R 0102 00 58
R 0080 00 DA
Q 0000 05 00
Q 0000 12 00
F 0000 00 17
R FF0F 00 17
W FF0F E8 01
F 0000 00 08
R FF0F 00 08
W FFFF FF 00
F 0000 1F 08
R FFFF 00 1F
W FF40 77 00
W 8000 99 00
R FF40 00 00
R 8000 00 00
R A000 00 00
R C000 00 A5
F 0000 1F 08
W FF50 01 00
F 0001 1F 08
R FF50 00 01
R 0000 00 00
R 0102 00 00

// File: all.f
src/gb_bus_pkg.sv
src/bus_if.sv
src/address_decoder.sv
src/io_registers.sv
src/work_ram.sv
src/read_mux.sv
src/gb_memory_system.sv
tb/gb_memory_system_tb.sv

// File: tb/gb_memory_system_tb.sv
// Testbench for the console system bus top level
// Replays bus operations from the stimulus file, then runs a
// random work RAM sweep through both the direct and echo windows

`timescale 1ns/1ps

module gb_memory_system_tb;

   localparam int SWEEP_COUNT = 64;
   localparam int MAX_LINES   = 256;

   logic                   clock;
   logic                   reset;
   gb_bus_pkg::addr_t      addr;
   gb_bus_pkg::data_t      wdata;
   logic                   we;
   logic                   re;
   gb_bus_pkg::int_flags_t int_req;
   gb_bus_pkg::data_t      flash_data;
   gb_bus_pkg::addr_t      flash_addr;
   logic                   flash_rd;
   gb_bus_pkg::data_t      rdata;
   gb_bus_pkg::int_flags_t if_flags;
   gb_bus_pkg::int_flags_t ie_flags;
   logic                   boot_done;

   // Operations loaded from the stimulus file
   logic [7:0]             stim_op   [MAX_LINES];
   gb_bus_pkg::addr_t      stim_addr [MAX_LINES];
   gb_bus_pkg::data_t      stim_data [MAX_LINES];
   gb_bus_pkg::data_t      stim_exp  [MAX_LINES];
   gb_bus_pkg::data_t      shadow    [gb_bus_pkg::WRAM_DEPTH];
   gb_bus_pkg::wram_addr_t sweep_index [SWEEP_COUNT];
   int                     line_count;
   int                     checks;
   int                     errors;
   int                     cycles;
   int                     cycle_limit;
   integer                 seed;

   // Boot flash unmapped, as written by the replayed operations
   logic                   boot_off;

   gb_memory_system gb_memory_system_i (
      .clock      (clock),
      .reset      (reset),
      .addr       (addr),
      .wdata      (wdata),
      .we         (we),
      .re         (re),
      .int_req    (int_req),
      .flash_data (flash_data),
      .flash_addr (flash_addr),
      .flash_rd   (flash_rd),
      .rdata      (rdata),
      .if_flags   (if_flags),
      .ie_flags   (ie_flags),
      .boot_done  (boot_done)
   );

   // Boot flash model
   assign flash_data = flash_addr[7:0] ^ 8'h5A;

   initial begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   // Watchdog
   always @(posedge clock) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timed out after %0d cycles without finishing the tests", cycles);
         $display("STATUS: FAIL");
         $finish;
      end
   end

   task automatic check_value(input string what, input logic [7:0] got,
                              input logic [7:0] expected);
      checks++;
      assert (got === expected) else begin
         $display("Mismatch at %0t: %s gave 0x%h, expected 0x%h", $time, what, got, expected);
         errors++;
      end
   endtask

   task automatic load_stimulus();
      integer            fd;
      integer            code;
      logic [7:0]        op;
      logic [8*128-1:0]  rest;
      gb_bus_pkg::addr_t a;
      gb_bus_pkg::data_t d;
      gb_bus_pkg::data_t e;
      line_count = 0;
      fd = $fopen("tb/bus_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file tb/bus_stim.txt");
         errors++;
      end else begin
         while (!$feof(fd) && line_count < MAX_LINES) begin
            code = $fscanf(fd, " %c", op);
            if (code == 1 && op == "#") begin
               code = $fgets(rest, fd);
            end else if (code == 1) begin
               code = $fscanf(fd, " %h %h %h", a, d, e);
               if (code != 3) begin
                  $display("Stimulus line %0d is malformed", line_count);
                  errors++;
               end
               stim_op[line_count]   = op;
               stim_addr[line_count] = a;
               stim_data[line_count] = d;
               stim_exp[line_count]  = e;
               line_count++;
            end
         end
         $fclose(fd);
      end
   endtask

   // Drive at a rising edge, release at the next, check at the falling edge
   task automatic run_operation(input int n);
      logic [7:0] op;
      logic       rd_exp;
      op = stim_op[n];
      // Flash strobe only for reads inside the window before boot is disabled
      rd_exp = (op == "R") && (stim_addr[n] <= gb_bus_pkg::BOOT_WINDOW_END) &&
               !boot_off;
      @(posedge clock);
      addr  <= stim_addr[n];
      wdata <= stim_data[n];
      case (op)
         "W": begin
            we      <= 1'b1;
            int_req <= stim_exp[n][4:0];
         end
         "R": re <= 1'b1;
         "Q": int_req <= stim_data[n][4:0];
         "F": ;
         default: begin
            $display("Unknown operation %c on stimulus line %0d", op, n);
            errors++;
         end
      endcase
      @(negedge clock);
      check_value("flash_rd", {7'd0, flash_rd}, {7'd0, rd_exp});
      @(posedge clock);
      we      <= 1'b0;
      re      <= 1'b0;
      int_req <= '0;
      if (op == "W" && stim_addr[n] == gb_bus_pkg::MMIO_BOOT) begin
         boot_off = stim_data[n][0];
      end
      @(negedge clock);
      if (op == "R") begin
         check_value($sformatf("read of 0x%h", stim_addr[n]), rdata, stim_exp[n]);
      end else if (op == "F") begin
         check_value("boot_done", {7'd0, boot_done}, stim_addr[n][7:0]);
         check_value("ie_flags", {3'd0, ie_flags}, stim_data[n]);
         check_value("if_flags", {3'd0, if_flags}, stim_exp[n]);
      end
   endtask

   task automatic random_sweep();
      gb_bus_pkg::data_t d;
      gb_bus_pkg::addr_t a;
      for (int i = 0; i < SWEEP_COUNT; i++) begin
         sweep_index[i] = gb_bus_pkg::wram_addr_t'($random(seed));
         d = gb_bus_pkg::data_t'($random(seed));
         shadow[sweep_index[i]] = d;
         @(posedge clock);
         addr  <= gb_bus_pkg::WRAM_START + sweep_index[i];
         wdata <= d;
         we    <= 1'b1;
      end
      @(posedge clock);
      we <= 1'b0;
      for (int i = 0; i < SWEEP_COUNT; i++) begin
         // Odd entries go through the echo window where it reaches
         if (i % 2 == 1 && sweep_index[i] < 13'h1E00) begin
            a = gb_bus_pkg::ECHO_START + sweep_index[i];
         end else begin
            a = gb_bus_pkg::WRAM_START + sweep_index[i];
         end
         @(posedge clock);
         addr <= a;
         re   <= 1'b1;
         @(posedge clock);
         re <= 1'b0;
         @(negedge clock);
         check_value($sformatf("sweep read of 0x%h", a), rdata, shadow[sweep_index[i]]);
      end
   endtask

   initial begin
      int replay_errors;
      reset       = 1'b1;
      addr        = '0;
      wdata       = '0;
      we          = 1'b0;
      re          = 1'b0;
      int_req     = '0;
      boot_off    = 1'b0;
      checks      = 0;
      errors      = 0;
      cycles      = 0;
      seed        = 32'hf482;
      cycle_limit = 1000000;
      load_stimulus();
      cycle_limit = 4 * line_count + 4 * (2 * SWEEP_COUNT) + 200;
      repeat (10) @(posedge clock);
      reset <= 1'b0;
      for (int n = 0; n < line_count; n++) begin
         run_operation(n);
      end
      replay_errors = errors;
      $display("Stimulus replay: %0d operations, %0d errors", line_count, replay_errors);
      random_sweep();
      $display("Random RAM sweep: %0d writes, %0d errors", SWEEP_COUNT,
               errors - replay_errors);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: src/gb_memory_system.sv
// Console system bus top level
// Drives the bus bundle from the ports and connects the decoder,
// I/O registers, work RAM, read path and boot flash strobes

`timescale 1ns/1ps

module gb_memory_system (
   input  logic                    clock,
   input  logic                    reset,
   input  gb_bus_pkg::addr_t       addr,
   input  gb_bus_pkg::data_t       wdata,
   input  logic                    we,
   input  logic                    re,
   input  gb_bus_pkg::int_flags_t  int_req,
   input  gb_bus_pkg::data_t       flash_data,
   output gb_bus_pkg::addr_t       flash_addr,
   output logic                    flash_rd,
   output gb_bus_pkg::data_t       rdata,
   output gb_bus_pkg::int_flags_t  if_flags,
   output gb_bus_pkg::int_flags_t  ie_flags,
   output logic                    boot_done
);

   bus_if bus ();

   gb_bus_pkg::region_t region;
   gb_bus_pkg::data_t   boot_reg;
   gb_bus_pkg::data_t   wram_data;

   // Host side of the bus
   assign bus.addr  = addr;
   assign bus.wdata = wdata;
   assign bus.we    = we;
   assign bus.re    = re;

   // Flash sees every address; only reads in its window strobe it
   assign flash_addr = addr;
   assign flash_rd   = re && (region == gb_bus_pkg::region_flash);

   address_decoder address_decoder_i (
      .bus       (bus),
      .boot_done (boot_done),
      .region    (region)
   );

   io_registers io_registers_i (
      .clock     (clock),
      .reset     (reset),
      .bus       (bus),
      .region    (region),
      .int_req   (int_req),
      .if_flags  (if_flags),
      .ie_flags  (ie_flags),
      .boot_done (boot_done),
      .boot_reg  (boot_reg)
   );

   work_ram work_ram_i (
      .clock  (clock),
      .bus    (bus),
      .region (region),
      .rdata  (wram_data)
   );

   read_mux read_mux_i (
      .clock      (clock),
      .reset      (reset),
      .bus        (bus),
      .region     (region),
      .flash_data (flash_data),
      .boot_reg   (boot_reg),
      .if_flags   (if_flags),
      .ie_flags   (ie_flags),
      .wram_data  (wram_data),
      .rdata      (rdata)
   );

endmodule

// File: src/read_mux.sv
// Read data return path
// Captures the region and the non-RAM byte of each read, then
// selects between RAM output and the captured byte one cycle later

`timescale 1ns/1ps

module read_mux (
   input  logic                    clock,
   input  logic                    reset,
   bus_if.target                   bus,
   input  gb_bus_pkg::region_t     region,
   input  gb_bus_pkg::data_t       flash_data,
   input  gb_bus_pkg::data_t       boot_reg,
   input  gb_bus_pkg::int_flags_t  if_flags,
   input  gb_bus_pkg::int_flags_t  ie_flags,
   input  gb_bus_pkg::data_t       wram_data,
   output gb_bus_pkg::data_t       rdata
);

   gb_bus_pkg::region_t rd_region;
   gb_bus_pkg::data_t   rd_byte;
   gb_bus_pkg::data_t   sel_byte;

   // Byte from the flash or a register, flags zero-extended
   always_comb begin
      case (region)
         gb_bus_pkg::region_flash: sel_byte = flash_data;
         gb_bus_pkg::region_if:    sel_byte = {3'b000, if_flags};
         gb_bus_pkg::region_ie:    sel_byte = {3'b000, ie_flags};
         gb_bus_pkg::region_boot:  sel_byte = boot_reg;
         default:                  sel_byte = gb_bus_pkg::UNMAPPED_DATA;
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rd_region <= gb_bus_pkg::region_unmapped;
      end else begin
         rd_region <= bus.re ? region : gb_bus_pkg::region_unmapped;
      end
   end

   always_ff @(posedge clock) begin
      rd_byte <= sel_byte;
   end

   // RAM data is already registered inside work_ram
   always_comb begin
      case (rd_region)
         gb_bus_pkg::region_wram:     rdata = wram_data;
         gb_bus_pkg::region_unmapped: rdata = gb_bus_pkg::UNMAPPED_DATA;
         default:                     rdata = rd_byte;
      endcase
   end

endmodule

// File: src/work_ram.sv
// 8 KiB work RAM with synchronous read
// Echo addresses are folded back onto the same words

`timescale 1ns/1ps

module work_ram (
   input  logic                 clock,
   bus_if.target                bus,
   input  gb_bus_pkg::region_t  region,
   output gb_bus_pkg::data_t    rdata
);

   gb_bus_pkg::data_t      mem [gb_bus_pkg::WRAM_DEPTH];
   gb_bus_pkg::addr_t      offset;
   gb_bus_pkg::wram_addr_t index;
   logic                   write_en;

   // Offset from the base of whichever window was hit
   assign offset = (bus.addr >= gb_bus_pkg::ECHO_START) ?
                   bus.addr - gb_bus_pkg::ECHO_START :
                   bus.addr - gb_bus_pkg::WRAM_START;

   assign index = gb_bus_pkg::wram_addr_t'(offset);

   assign write_en = bus.we && (region == gb_bus_pkg::region_wram);

   // Read-first: a read in the write cycle sees the old byte
   always_ff @(posedge clock) begin
      if (write_en) begin
         mem[index] <= bus.wdata;
      end
      rdata <= mem[index];
   end

endmodule

// File: src/io_registers.sv
// Interrupt flag, interrupt enable and boot-disable registers
// IF collects request pulses and can be overwritten from the bus;
// IE and the boot register load on bus writes

`timescale 1ns/1ps

module io_registers (
   input  logic                    clock,
   input  logic                    reset,
   bus_if.target                   bus,
   input  gb_bus_pkg::region_t     region,
   input  gb_bus_pkg::int_flags_t  int_req,
   output gb_bus_pkg::int_flags_t  if_flags,
   output gb_bus_pkg::int_flags_t  ie_flags,
   output logic                    boot_done,
   output gb_bus_pkg::data_t       boot_reg
);

   logic write_if;
   logic write_ie;
   logic write_boot;

   // Write strobes per register
   assign write_if   = bus.we && (region == gb_bus_pkg::region_if);
   assign write_ie   = bus.we && (region == gb_bus_pkg::region_ie);
   assign write_boot = bus.we && (region == gb_bus_pkg::region_boot);

   // Interrupt flags
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_flags <= '0;
      end else if (write_if) begin
         // A bus write overrides requests arriving in the same cycle
         if_flags <= bus.wdata[gb_bus_pkg::INT_JOYPAD:0];
      end else begin
         if_flags <= if_flags | int_req;
      end
   end

   // Interrupt enable
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         ie_flags <= '0;
      end else if (write_ie) begin
         ie_flags <= bus.wdata[gb_bus_pkg::INT_JOYPAD:0];
      end
   end

   // Boot-disable register, full byte kept for read back
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         boot_reg <= '0;
      end else if (write_boot) begin
         boot_reg <= bus.wdata;
      end
   end

   // Bit 0 unmaps the boot flash
   assign boot_done = boot_reg[0];

endmodule

// File: src/address_decoder.sv
// Address decoder for the console memory map
// Maps the bus address onto one region code; the boot flash
// window is only visible until boot is disabled

`timescale 1ns/1ps

module address_decoder (
   bus_if.target                bus,
   input  logic                 boot_done,
   output gb_bus_pkg::region_t  region
);

   logic in_boot_window;
   logic in_wram;
   logic in_echo;

   // Range checks
   assign in_boot_window = (bus.addr <= gb_bus_pkg::BOOT_WINDOW_END);

   assign in_wram = (bus.addr >= gb_bus_pkg::WRAM_START) &&
                    (bus.addr <= gb_bus_pkg::WRAM_END);

   assign in_echo = (bus.addr >= gb_bus_pkg::ECHO_START) &&
                    (bus.addr <= gb_bus_pkg::ECHO_END);

   always_comb begin
      region = gb_bus_pkg::region_unmapped;

      if (in_boot_window && !boot_done) begin
         region = gb_bus_pkg::region_flash;
      end else if (in_wram || in_echo) begin
         // Echo space lands on the same RAM
         region = gb_bus_pkg::region_wram;
      end else begin
         case (bus.addr)
            gb_bus_pkg::MMIO_IF: begin
               region = gb_bus_pkg::region_if;
            end
            gb_bus_pkg::MMIO_IE: begin
               region = gb_bus_pkg::region_ie;
            end
            gb_bus_pkg::MMIO_BOOT: begin
               region = gb_bus_pkg::region_boot;
            end
            default: begin
               region = gb_bus_pkg::region_unmapped;
            end
         endcase
      end
   end

endmodule

// File: src/bus_if.sv
// System bus bundle between the top level and the bus targets
// Address, write data and the read and write strobes

`timescale 1ns/1ps

interface bus_if;

   gb_bus_pkg::addr_t addr;
   gb_bus_pkg::data_t wdata;
   logic              we;
   logic              re;

   // Top level side
   modport host (
      output addr, wdata, we, re
   );

   // Decoder, registers, RAM and read path
   modport target (
      input addr, wdata, we, re
   );

endinterface

// File: src/gb_bus_pkg.sv
// Shared definitions for the console system bus
// Bus and register types, memory map addresses, interrupt bit
// indices and the region code produced by the address decoder

package gb_bus_pkg;

   // Bus widths
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   // One flag per interrupt source
   typedef logic [4:0]  int_flags_t;

   // Word index into the 8 KiB work RAM
   typedef logic [12:0] wram_addr_t;

   // Interrupt bit positions in IF and IE
   localparam int INT_VBLANK = 0;
   localparam int INT_LCDC   = 1;
   localparam int INT_TIMER  = 2;
   localparam int INT_SERIAL = 3;
   localparam int INT_JOYPAD = 4;

   // Boot flash is mapped from 0x0000 up to this address
   localparam addr_t BOOT_WINDOW_END = 16'h0102;

   // Work RAM and its mirror
   localparam addr_t WRAM_START = 16'hC000;
   localparam addr_t WRAM_END   = 16'hDFFF;
   localparam addr_t ECHO_START = 16'hE000;
   localparam addr_t ECHO_END   = 16'hFDFF;

   // Memory mapped registers
   localparam addr_t MMIO_IF   = 16'hFF0F;
   localparam addr_t MMIO_BOOT = 16'hFF50;
   localparam addr_t MMIO_IE   = 16'hFFFF;

   localparam int    WRAM_DEPTH    = 8192;
   localparam data_t UNMAPPED_DATA = 8'h00;

   // Exactly one region per bus address
   typedef enum logic [2:0] {
      region_flash,
      region_wram,
      region_if,
      region_ie,
      region_boot,
      region_unmapped
   } region_t;

endpackage
